// ==== files.f ====
logic/gemm_pkg.sv
logic/operand_buffer.sv
logic/gemm_pe.sv
logic/mm_engine.sv
logic/dma_engine.sv
logic/gemm_top.sv
verification/axi_mem_model.sv
verification/tb_gemm_top.sv

// ==== logic/dma_engine.sv ====
// ----------------------------------------------------------
// loads A and B over AXI read, runs the engine, writes C
// read ids 0 and 1 only, no error responses, aligned bursts
// mat_k_i in 4..16, multiple of 4, held during a run
// ----------------------------------------------------------
`timescale 1ns/10ps

module dma_engine #(
    parameter int DW       = 32,
    parameter int SA_WIDTH = 4,
    parameter int ACC_W    = 2*DW+1
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [gemm_pkg::ADDR_W-1:0]   mat_a_addr_i,
    input  logic [gemm_pkg::ADDR_W-1:0]   mat_b_addr_i,
    input  logic [gemm_pkg::ADDR_W-1:0]   mat_c_addr_i,
    input  logic [gemm_pkg::K_W-1:0]      mat_k_i,
    input  logic                          start_i,
    output logic                          done_o,
    output logic                          ar_valid_o,
    input  logic                          ar_ready_i,
    output logic [gemm_pkg::ADDR_W-1:0]   ar_addr_o,
    output logic [gemm_pkg::ID_W-1:0]     ar_id_o,
    output logic [gemm_pkg::LEN_W-1:0]    ar_len_o,
    input  logic                          r_valid_i,
    output logic                          r_ready_o,
    input  logic [DW-1:0]                 r_data_i,
    input  logic [gemm_pkg::ID_W-1:0]     r_id_i,
    input  logic                          r_last_i,
    output logic                          aw_valid_o,
    input  logic                          aw_ready_i,
    output logic [gemm_pkg::ADDR_W-1:0]   aw_addr_o,
    output logic [gemm_pkg::LEN_W-1:0]    aw_len_o,
    output logic                          w_valid_o,
    input  logic                          w_ready_i,
    output logic [DW-1:0]                 w_data_o,
    output logic                          w_last_o,
    input  logic                          b_valid_i,
    output logic                          b_ready_o,
    output logic                          a_wr_en_o,
    output logic [gemm_pkg::BUF_AW-1:0]   a_wr_addr_o,
    output logic [gemm_pkg::BUF_DW-1:0]   a_wr_data_o,
    output logic                          b_wr_en_o,
    output logic [gemm_pkg::BUF_AW-1:0]   b_wr_addr_o,
    output logic [gemm_pkg::BUF_DW-1:0]   b_wr_data_o,
    output logic                          mm_start_o,
    input  logic                          mm_done_i,
    input  logic signed [ACC_W-1:0]       accum_i [SA_WIDTH][SA_WIDTH]
);

    localparam int SW_B   = $clog2(SA_WIDTH);
    localparam int WC_W   = 2*SW_B;
    localparam int BEAT_W = $clog2(gemm_pkg::BEATS_PER_ROW);
    localparam int BC_W   = gemm_pkg::K_W - 2;
    // stream 0 fills buffer A, stream 1 buffer B
    localparam logic [gemm_pkg::ID_W-1:0] SID [2] = '{gemm_pkg::ID_A, gemm_pkg::ID_B};

    typedef enum logic [2:0] {
        IDLE, ADDR_A, ADDR_B, LOAD, WAIT_MM, ADDR_C, WRITE_C, RESP
    } state_t;

    state_t                      state;
    state_t                      state_n;
    logic [BC_W-1:0]             burst_cnt;
    logic [BC_W-1:0]             burst_last;
    logic                        ar_hs;
    logic                        r_hs;
    logic [WC_W-1:0]             w_cnt;
    logic [BEAT_W-1:0]           beat_cnt [2];
    logic [gemm_pkg::K_W-1:0]    row_cnt [2];
    logic [gemm_pkg::BUF_DW-1:0] pack [2];
    logic                        wr_en [2];

    // K/4 bursts per matrix
    assign burst_last = mat_k_i[gemm_pkg::K_W-1:2] - BC_W'(1);
    assign ar_hs      = ar_valid_o && ar_ready_i;
    assign r_hs       = r_valid_i && r_ready_o;

    always_comb begin
        state_n = state;
        case (state)
            IDLE:    if (start_i) state_n = ADDR_A;
            ADDR_A:  if (ar_hs && burst_cnt == burst_last) state_n = ADDR_B;
            ADDR_B:  if (ar_hs && burst_cnt == burst_last) state_n = LOAD;
            // both buffers hold K rows
            LOAD:    if (row_cnt[0] == mat_k_i && row_cnt[1] == mat_k_i) state_n = WAIT_MM;
            WAIT_MM: if (mm_done_i) state_n = ADDR_C;
            ADDR_C:  if (aw_ready_i) state_n = WRITE_C;
            WRITE_C: if (w_ready_i && w_last_o) state_n = RESP;
            RESP:    if (b_valid_i) state_n = IDLE;
            default: state_n = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= IDLE;
            burst_cnt  <= '0;
            w_cnt      <= '0;
            mm_start_o <= 1'b0;
        end else begin
            state      <= state_n;
            mm_start_o <= (state == LOAD) && (state_n == WAIT_MM);
            // wraps to 0 between A and B
            if (ar_hs) begin
                burst_cnt <= (burst_cnt == burst_last) ? '0 : burst_cnt + 1'b1;
            end
            // 16 beats wrap back to 0
            if (w_valid_o && w_ready_i) begin
                w_cnt <= w_cnt + 1'b1;
            end
        end
    end

    // per-stream row packing, counters restart on an accepted start
    always_ff @(posedge clk) begin
        for (int s = 0; s < 2; s++) begin
            if (!rst_n || (done_o && start_i)) begin
                beat_cnt[s] <= '0;
                row_cnt[s]  <= '0;
                wr_en[s]    <= 1'b0;
            end else begin
                wr_en[s] <= 1'b0;
                if (r_hs && r_id_i == SID[s]) begin
                    beat_cnt[s] <= beat_cnt[s] + 1'b1;
                    // row write lands the cycle after beat 3
                    wr_en[s]    <= beat_cnt[s] == BEAT_W'(gemm_pkg::BEATS_PER_ROW - 1);
                end
                if (wr_en[s]) begin
                    row_cnt[s] <= row_cnt[s] + 1'b1;
                end
            end
        end
    end

    // shift right so beat n settles in lane n
    always_ff @(posedge clk) begin
        for (int s = 0; s < 2; s++) begin
            if (r_hs && r_id_i == SID[s]) begin
                pack[s] <= {r_data_i, pack[s][gemm_pkg::BUF_DW-1:DW]};
            end
        end
    end

    assign done_o = (state == IDLE);

    // read address, A bursts then B bursts
    assign ar_valid_o = (state == ADDR_A) || (state == ADDR_B);
    assign ar_id_o    = (state == ADDR_B) ? gemm_pkg::ID_B : gemm_pkg::ID_A;
    assign ar_addr_o  = ((state == ADDR_B) ? mat_b_addr_i : mat_a_addr_i)
                      + gemm_pkg::ADDR_W'(burst_cnt) * gemm_pkg::ADDR_W'(gemm_pkg::BURST_BYTES);
    assign ar_len_o   = gemm_pkg::LEN_W'(gemm_pkg::BURST_LEN - 1);
    // data may return before the last address goes out
    assign r_ready_o  = ar_valid_o || (state == LOAD);

    assign a_wr_en_o   = wr_en[0];
    assign a_wr_addr_o = row_cnt[0][gemm_pkg::BUF_AW-1:0];
    assign a_wr_data_o = pack[0];
    assign b_wr_en_o   = wr_en[1];
    assign b_wr_addr_o = row_cnt[1][gemm_pkg::BUF_AW-1:0];
    assign b_wr_data_o = pack[1];

    // C goes out row-major, low DW bits of each accumulator
    assign aw_valid_o = (state == ADDR_C);
    assign aw_addr_o  = mat_c_addr_i;
    assign aw_len_o   = gemm_pkg::LEN_W'(gemm_pkg::BURST_LEN - 1);
    assign w_valid_o  = (state == WRITE_C);
    assign w_data_o   = accum_i[w_cnt[WC_W-1:SW_B]][w_cnt[SW_B-1:0]][DW-1:0];
    assign w_last_o   = (w_cnt == WC_W'(gemm_pkg::BURST_LEN - 1));
    assign b_ready_o  = (state == RESP);

    // stalled address holds
    a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o));

    // memory answers on the two read streams only
    a_r_id: assert property (@(posedge clk) disable iff (!rst_n)
        r_valid_i |-> (r_id_i == gemm_pkg::ID_A) || (r_id_i == gemm_pkg::ID_B));

    // every read burst ends on a row boundary
    a_r_last: assert property (@(posedge clk) disable iff (!rst_n)
        r_hs && r_last_i |->
        ((r_id_i == gemm_pkg::ID_A) ? beat_cnt[0] : beat_cnt[1]) == BEAT_W'(3));

    // w_last closes the burst, no beat follows it
    a_w_last: assert property (@(posedge clk) disable iff (!rst_n)
        w_valid_o && w_ready_i && w_last_o |=> !w_valid_o && w_cnt == '0);

endmodule

// ==== logic/gemm_pe.sv ====
// ----------------------------------------------------------
// signed multiply-accumulate cell of the systolic grid
// accumulator and pass registers zero on clear
// ----------------------------------------------------------
`timescale 1ns/10ps

module gemm_pe #(
    parameter int DW    = 32,
    parameter int ACC_W = 2*DW+1
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    clear_i,
    input  logic                    en_i,
    input  logic [DW-1:0]           a_i,
    input  logic [DW-1:0]           b_i,
    output logic [DW-1:0]           a_o,
    output logic [DW-1:0]           b_o,
    output logic signed [ACC_W-1:0] acc_o
);

    logic signed [2*DW-1:0] prod;

    // full-width signed product
    assign prod = $signed(a_i) * $signed(b_i);

    always_ff @(posedge clk) begin
        if (!rst_n || clear_i) begin
            acc_o <= '0;
            a_o   <= '0;
            b_o   <= '0;
        end else if (en_i) begin
            // sign-extended into the guard bit
            acc_o <= acc_o + ACC_W'(prod);
            // a moves right, b moves down
            a_o   <= a_i;
            b_o   <= b_i;
        end
    end

    // engine never clears mid-run
    a_clear_en: assert property (@(posedge clk) disable iff (!rst_n)
        !(clear_i && en_i));

endmodule

// ==== logic/gemm_pkg.sv ====
// ----------------------------------------------------------
// widths and burst constants shared by the gemm blocks
// one 16-beat burst of 32-bit words fills four buffer rows
// ----------------------------------------------------------
package gemm_pkg;

    // byte addresses, burst aligned
    localparam int ADDR_W = 32;
    localparam int ID_W   = 4;
    localparam int LEN_W  = 8;
    // k runs 4..16, so five bits
    localparam int K_W    = 5;

    // one buffer row = four 32-bit lanes
    localparam int BUF_DW        = 128;
    localparam int BUF_AW        = 4;
    localparam int BEATS_PER_ROW = 4;

    // arlen/awlen carry BURST_LEN-1
    localparam int BURST_LEN   = 16;
    localparam int BURST_BYTES = 64;

    // read streams, A then B
    localparam logic [ID_W-1:0] ID_A = ID_W'(0);
    localparam logic [ID_W-1:0] ID_B = ID_W'(1);

endpackage

// ==== logic/gemm_top.sv ====
// ----------------------------------------------------------
// matrix-multiply accelerator, C = A x B for 4 x K by K x 4
// A column-major and B row-major in memory, C row-major
// ----------------------------------------------------------
`timescale 1ns/10ps

module gemm_top #(
    parameter int DW       = 32,
    parameter int SA_WIDTH = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [gemm_pkg::ADDR_W-1:0] mat_a_addr_i,
    input  logic [gemm_pkg::ADDR_W-1:0] mat_b_addr_i,
    input  logic [gemm_pkg::ADDR_W-1:0] mat_c_addr_i,
    input  logic [gemm_pkg::K_W-1:0]    mat_k_i,
    input  logic                        start_i,
    output logic                        done_o,
    output logic                        ar_valid_o,
    input  logic                        ar_ready_i,
    output logic [gemm_pkg::ADDR_W-1:0] ar_addr_o,
    output logic [gemm_pkg::ID_W-1:0]   ar_id_o,
    output logic [gemm_pkg::LEN_W-1:0]  ar_len_o,
    input  logic                        r_valid_i,
    output logic                        r_ready_o,
    input  logic [DW-1:0]               r_data_i,
    input  logic [gemm_pkg::ID_W-1:0]   r_id_i,
    input  logic                        r_last_i,
    output logic                        aw_valid_o,
    input  logic                        aw_ready_i,
    output logic [gemm_pkg::ADDR_W-1:0] aw_addr_o,
    output logic [gemm_pkg::LEN_W-1:0]  aw_len_o,
    output logic                        w_valid_o,
    input  logic                        w_ready_i,
    output logic [DW-1:0]               w_data_o,
    output logic                        w_last_o,
    input  logic                        b_valid_i,
    output logic                        b_ready_o
);

    // one guard bit over the full product
    localparam int ACC_W = 2*DW+1;

    logic                        a_wr_en;
    logic                        b_wr_en;
    logic [gemm_pkg::BUF_AW-1:0] a_wr_addr;
    logic [gemm_pkg::BUF_AW-1:0] b_wr_addr;
    logic [gemm_pkg::BUF_DW-1:0] a_wr_data;
    logic [gemm_pkg::BUF_DW-1:0] b_wr_data;
    logic [gemm_pkg::BUF_AW-1:0] a_rd_addr;
    logic [gemm_pkg::BUF_AW-1:0] b_rd_addr;
    logic [gemm_pkg::BUF_DW-1:0] a_rd_data;
    logic [gemm_pkg::BUF_DW-1:0] b_rd_data;
    logic                        mm_start;
    logic                        mm_done;
    logic                        mm_clear;
    logic                        mm_en;
    logic [DW-1:0]               a_edge [SA_WIDTH];
    logic [DW-1:0]               b_edge [SA_WIDTH];
    // a_h[i][j] enters PE(i,j) from the left, b_v[i][j] from above
    logic [DW-1:0]               a_h [SA_WIDTH][SA_WIDTH+1];
    logic [DW-1:0]               b_v [SA_WIDTH+1][SA_WIDTH];
    logic signed [ACC_W-1:0]     accum [SA_WIDTH][SA_WIDTH];

    dma_engine #(.DW(DW), .SA_WIDTH(SA_WIDTH), .ACC_W(ACC_W)) i_dma (
        .clk, .rst_n, .mat_a_addr_i, .mat_b_addr_i, .mat_c_addr_i, .mat_k_i,
        .start_i, .done_o,
        .ar_valid_o, .ar_ready_i, .ar_addr_o, .ar_id_o, .ar_len_o,
        .r_valid_i, .r_ready_o, .r_data_i, .r_id_i, .r_last_i,
        .aw_valid_o, .aw_ready_i, .aw_addr_o, .aw_len_o,
        .w_valid_o, .w_ready_i, .w_data_o, .w_last_o, .b_valid_i, .b_ready_o,
        .a_wr_en_o(a_wr_en), .a_wr_addr_o(a_wr_addr), .a_wr_data_o(a_wr_data),
        .b_wr_en_o(b_wr_en), .b_wr_addr_o(b_wr_addr), .b_wr_data_o(b_wr_data),
        .mm_start_o(mm_start), .mm_done_i(mm_done), .accum_i(accum)
    );

    operand_buffer i_buf_a (
        .clk, .wr_en_i(a_wr_en), .wr_addr_i(a_wr_addr), .wr_data_i(a_wr_data),
        .rd_addr_i(a_rd_addr), .rd_data_o(a_rd_data)
    );

    operand_buffer i_buf_b (
        .clk, .wr_en_i(b_wr_en), .wr_addr_i(b_wr_addr), .wr_data_i(b_wr_data),
        .rd_addr_i(b_rd_addr), .rd_data_o(b_rd_data)
    );

    mm_engine #(.DW(DW), .SA_WIDTH(SA_WIDTH)) i_mm (
        .clk, .rst_n, .start_i(mm_start), .mat_k_i,
        .a_row_i(a_rd_data), .b_row_i(b_rd_data), .done_o(mm_done),
        .a_rd_addr_o(a_rd_addr), .b_rd_addr_o(b_rd_addr),
        .clear_o(mm_clear), .en_o(mm_en), .a_edge_o(a_edge), .b_edge_o(b_edge)
    );

    genvar i, j;
    generate
        for (i = 0; i < SA_WIDTH; i++) begin : g_row
            // skewed lanes enter at the left and top edges
            assign a_h[i][0] = a_edge[i];
            assign b_v[0][i] = b_edge[i];
            for (j = 0; j < SA_WIDTH; j++) begin : g_col
                gemm_pe #(.DW(DW), .ACC_W(ACC_W)) i_pe (
                    .clk, .rst_n, .clear_i(mm_clear), .en_i(mm_en),
                    .a_i(a_h[i][j]), .b_i(b_v[i][j]),
                    .a_o(a_h[i][j+1]), .b_o(b_v[i+1][j]), .acc_o(accum[i][j])
                );
            end
        end
    endgenerate

endmodule

// ==== logic/mm_engine.sv ====
// ----------------------------------------------------------
// streams buffer rows into the PE grid with diagonal skew
// done pulses K + 2*SA_WIDTH cycles after start
// mat_k_i must hold steady for the whole run
// ----------------------------------------------------------
`timescale 1ns/10ps

module mm_engine #(
    parameter int DW       = 32,
    parameter int SA_WIDTH = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start_i,
    input  logic [gemm_pkg::K_W-1:0]    mat_k_i,
    input  logic [gemm_pkg::BUF_DW-1:0] a_row_i,
    input  logic [gemm_pkg::BUF_DW-1:0] b_row_i,
    output logic                        done_o,
    output logic [gemm_pkg::BUF_AW-1:0] a_rd_addr_o,
    output logic [gemm_pkg::BUF_AW-1:0] b_rd_addr_o,
    output logic                        clear_o,
    output logic                        en_o,
    output logic [DW-1:0]               a_edge_o [SA_WIDTH],
    output logic [DW-1:0]               b_edge_o [SA_WIDTH]
);

    localparam int CNT_W = gemm_pkg::K_W + 1;

    logic             run;
    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] k_ext;
    // buffer output carries a real row
    logic             rd_vld;

    assign k_ext = CNT_W'(mat_k_i);

    // cnt 0 is the cycle after start
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run <= 1'b0;
            cnt <= '0;
        end else if (start_i) begin
            run <= 1'b1;
            cnt <= '0;
        end else if (done_o) begin
            run <= 1'b0;
        end else if (run) begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || start_i) begin
            rd_vld <= 1'b0;
        end else begin
            rd_vld <= run && (cnt < k_ext);
        end
    end

    // rows 0..K-1, later addresses are masked by rd_vld
    assign a_rd_addr_o = cnt[gemm_pkg::BUF_AW-1:0];
    assign b_rd_addr_o = cnt[gemm_pkg::BUF_AW-1:0];

    assign clear_o = start_i;
    // first row at the edge on cnt 1, last PE busy until K+2S-2
    assign en_o    = run && (cnt != '0) && (cnt <= k_ext + CNT_W'(2*SA_WIDTH - 2));
    assign done_o  = run && (cnt == k_ext + CNT_W'(2*SA_WIDTH - 1));

    genvar i;
    generate
        for (i = 0; i < SA_WIDTH; i++) begin : g_lane
            logic [DW-1:0] a_in;
            logic [DW-1:0] b_in;

            // zeros outside the operand window
            assign a_in = rd_vld ? a_row_i[i*DW +: DW] : '0;
            assign b_in = rd_vld ? b_row_i[i*DW +: DW] : '0;

            if (i == 0) begin : g_direct
                assign a_edge_o[i] = a_in;
                assign b_edge_o[i] = b_in;
            end else begin : g_delay
                // lane i waits i cycles
                logic [DW-1:0] a_dly [i];
                logic [DW-1:0] b_dly [i];

                always_ff @(posedge clk) begin
                    if (!rst_n || start_i) begin
                        for (int d = 0; d < i; d++) begin
                            a_dly[d] <= '0;
                            b_dly[d] <= '0;
                        end
                    end else begin
                        a_dly[0] <= a_in;
                        b_dly[0] <= b_in;
                        for (int d = 1; d < i; d++) begin
                            a_dly[d] <= a_dly[d-1];
                            b_dly[d] <= b_dly[d-1];
                        end
                    end
                end

                assign a_edge_o[i] = a_dly[i-1];
                assign b_edge_o[i] = b_dly[i-1];
            end
        end
    endgenerate

    // dma must wait for done before the next start
    a_no_restart: assert property (@(posedge clk) disable iff (!rst_n)
        start_i |-> !run);

endmodule

// ==== logic/operand_buffer.sv ====
// ----------------------------------------------------------
// 16 x 128-bit operand RAM, one write and one read port
// read is registered, a same-address write returns old data
// ----------------------------------------------------------
`timescale 1ns/10ps

module operand_buffer (
    input  logic                        clk,
    input  logic                        wr_en_i,
    input  logic [gemm_pkg::BUF_AW-1:0] wr_addr_i,
    input  logic [gemm_pkg::BUF_DW-1:0] wr_data_i,
    input  logic [gemm_pkg::BUF_AW-1:0] rd_addr_i,
    output logic [gemm_pkg::BUF_DW-1:0] rd_data_o
);

    // row k holds operand step k
    logic [gemm_pkg::BUF_DW-1:0] mem [2**gemm_pkg::BUF_AW];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
        // data one cycle after the address
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -f files.f --top-module tb_gemm_top -o sim_tb \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || echo "simulator returned an error" >> sim.log
cat sim.log
! grep -q "TB FAILED" sim.log && grep -q "TB PASSED" sim.log && exit 0 || exit 1

// ==== verification/axi_mem_model.sv ====
// ----------------------------------------------------------
// word memory behind the AXI ports, 4 KB, 16-beat bursts only
// stall_i bits hold off ar_ready, r_valid, aw_ready, w_ready
// bad burst addresses and lengths are counted as errors
// ----------------------------------------------------------
`timescale 1ns/10ps

module axi_mem_model #(
    parameter int A_LO = 'h000,
    parameter int A_HI = 'h200,
    parameter int B_LO = 'h400,
    parameter int B_HI = 'h600,
    parameter int C_LO = 'h800,
    parameter int C_HI = 'h900
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [3:0]  stall_i,
    input  logic        ld_en_i,
    input  logic [9:0]  ld_addr_i,
    input  logic [31:0] ld_data_i,
    input  logic        ar_valid_i,
    output logic        ar_ready_o,
    input  logic [31:0] ar_addr_i,
    input  logic [3:0]  ar_id_i,
    input  logic [7:0]  ar_len_i,
    output logic        r_valid_o,
    input  logic        r_ready_i,
    output logic [31:0] r_data_o,
    output logic [3:0]  r_id_o,
    output logic        r_last_o,
    input  logic        aw_valid_i,
    output logic        aw_ready_o,
    input  logic [31:0] aw_addr_i,
    input  logic [7:0]  aw_len_i,
    output logic        w_ready_o,
    input  logic        w_valid_i,
    input  logic [31:0] w_data_i,
    input  logic        w_last_i,
    output logic        b_valid_o,
    input  logic        b_ready_i,
    output int          wr_bursts_o,
    output int          addr_err_o
);

    logic [31:0] mem [1024];
    // pending read bursts, served in order
    logic [31:0] rq_addr [8];
    logic [3:0]  rq_id [8];
    logic [2:0]  rq_wr;
    logic [2:0]  rq_rd;
    logic [3:0]  rq_cnt;
    logic [3:0]  r_beat;
    logic        r_hold;
    logic [31:0] w_base;
    logic [3:0]  w_beat;
    logic        w_act;
    logic        ar_hs;
    logic        r_hs;

    assign ar_ready_o = !stall_i[0] && (rq_cnt < 4'd8);
    assign ar_hs      = ar_valid_i && ar_ready_o;
    // valid sticks once shown
    assign r_valid_o  = (rq_cnt != 0) && (!stall_i[1] || r_hold);
    assign r_hs       = r_valid_o && r_ready_i;
    assign r_data_o   = mem[rq_addr[rq_rd][11:2] + 10'(r_beat)];
    assign r_id_o     = rq_id[rq_rd];
    assign r_last_o   = (r_beat == 4'd15);
    assign aw_ready_o = !stall_i[2] && !w_act && !b_valid_o;
    assign w_ready_o  = !stall_i[3] && w_act;

    always @(posedge clk) begin
        int n_err;
        n_err = 0;
        if (ld_en_i) begin
            mem[ld_addr_i] <= ld_data_i;
        end
        if (!rst_n) begin
            rq_wr <= '0;
            rq_rd <= '0;
            rq_cnt <= '0;
            r_beat <= '0;
            r_hold <= 1'b0;
            w_act <= 1'b0;
            w_beat <= '0;
            b_valid_o <= 1'b0;
            wr_bursts_o <= 0;
            addr_err_o <= 0;
        end else begin
            r_hold <= r_valid_o && !r_ready_i;
            if (ar_hs) begin
                rq_addr[rq_wr] <= ar_addr_i;
                rq_id[rq_wr] <= ar_id_i;
                rq_wr <= rq_wr + 1'b1;
                if (!((ar_addr_i >= A_LO && ar_addr_i + 64 <= A_HI) ||
                      (ar_addr_i >= B_LO && ar_addr_i + 64 <= B_HI))) begin
                    $display("read burst at %08h lies outside the A and B regions",
                             ar_addr_i);
                    n_err++;
                end
                // only 16-beat bursts are served
                if (ar_len_i != 8'd15) begin
                    $display("read burst asks for %0d beats instead of 16", ar_len_i + 1);
                    n_err++;
                end
            end
            if (r_hs) begin
                r_beat <= r_beat + 1'b1;
                if (r_last_o) begin
                    rq_rd <= rq_rd + 1'b1;
                end
            end
            rq_cnt <= rq_cnt + 4'(ar_hs) - 4'(r_hs && r_last_o);
            if (aw_valid_i && aw_ready_o) begin
                w_base <= aw_addr_i;
                w_beat <= '0;
                w_act <= 1'b1;
                if (!(aw_addr_i >= C_LO && aw_addr_i + 64 <= C_HI)) begin
                    $display("write burst at %08h lies outside the C region", aw_addr_i);
                    n_err++;
                end
                if (aw_len_i != 8'd15) begin
                    $display("write burst announces %0d beats instead of 16", aw_len_i + 1);
                    n_err++;
                end
            end
            if (w_valid_i && w_ready_o) begin
                mem[w_base[11:2] + 10'(w_beat)] <= w_data_i;
                w_beat <= w_beat + 1'b1;
                if (w_last_i != (w_beat == 4'd15)) begin
                    $display("write burst last flag came on beat %0d", w_beat);
                    n_err++;
                end
                if (w_last_i) begin
                    w_act <= 1'b0;
                    b_valid_o <= 1'b1;
                end
            end
            if (b_valid_o && b_ready_i) begin
                b_valid_o <= 1'b0;
                wr_bursts_o <= wr_bursts_o + 1;
            end
            addr_err_o <= addr_err_o + n_err;
        end
    end

endmodule

// ==== verification/tb_gemm_top.sv ====
// ----------------------------------------------------------
// six runs of the accelerator against a software reference
// set s uses A at s%2 slot, B at s%2 slot, C at s%4 slot
// ----------------------------------------------------------
`timescale 1ns/10ps

module tb_gemm_top;

    localparam int NRUN  = 6;
    localparam int LIMIT = 400 * NRUN;

    logic clk = 1'b0;
    logic rst_n = 1'b0;
    logic [31:0] a_addr = '0, b_addr = '0, c_addr = '0;
    logic [4:0]  mat_k = 5'd4;
    logic start = 1'b0;
    logic done;
    logic ar_valid, ar_ready, r_valid, r_ready, r_last, aw_valid, aw_ready;
    logic w_valid, w_ready, w_last, b_valid, b_ready;
    logic [31:0] ar_addr, aw_addr, r_data, w_data;
    logic [3:0]  ar_id, r_id;
    logic [7:0]  ar_len, aw_len;
    logic [3:0]  stall = '0;
    logic stall_en = 1'b0;
    logic ld_en = 1'b0;
    logic [9:0]  ld_addr = '0;
    logic [31:0] ld_data = '0;
    int wr_bursts, addr_err;
    logic [31:0] lfsr = 32'h2d49_0d52;
    int a_m [NRUN][4][16];
    int b_m [NRUN][16][4];
    int k_of [NRUN] = '{4, 16, 8, 8, 4, 12};
    int pend [$];
    int mism = 0, other = 0, checked = 0, cycles = 0;

    always #2 clk = ~clk;

    gemm_top #(.DW(32), .SA_WIDTH(4)) i_dut (
        .clk, .rst_n, .mat_a_addr_i(a_addr), .mat_b_addr_i(b_addr),
        .mat_c_addr_i(c_addr), .mat_k_i(mat_k), .start_i(start), .done_o(done),
        .ar_valid_o(ar_valid), .ar_ready_i(ar_ready), .ar_addr_o(ar_addr),
        .ar_id_o(ar_id), .ar_len_o(ar_len), .r_valid_i(r_valid), .r_ready_o(r_ready),
        .r_data_i(r_data), .r_id_i(r_id), .r_last_i(r_last),
        .aw_valid_o(aw_valid), .aw_ready_i(aw_ready), .aw_addr_o(aw_addr),
        .aw_len_o(aw_len), .w_valid_o(w_valid), .w_ready_i(w_ready),
        .w_data_o(w_data), .w_last_o(w_last), .b_valid_i(b_valid), .b_ready_o(b_ready)
    );

    axi_mem_model i_mem (
        .clk, .rst_n, .stall_i(stall), .ld_en_i(ld_en), .ld_addr_i(ld_addr),
        .ld_data_i(ld_data), .ar_valid_i(ar_valid), .ar_ready_o(ar_ready),
        .ar_addr_i(ar_addr), .ar_id_i(ar_id), .ar_len_i(ar_len),
        .r_valid_o(r_valid), .r_ready_i(r_ready),
        .r_data_o(r_data), .r_id_o(r_id), .r_last_o(r_last), .aw_valid_i(aw_valid),
        .aw_ready_o(aw_ready), .aw_addr_i(aw_addr), .aw_len_i(aw_len),
        .w_ready_o(w_ready),
        .w_valid_i(w_valid), .w_data_i(w_data), .w_last_i(w_last),
        .b_valid_o(b_valid), .b_ready_i(b_ready), .wr_bursts_o(wr_bursts),
        .addr_err_o(addr_err)
    );

    // galois step, one per bit taken
    function automatic logic [31:0] random_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    // sum over k of A[i][k]*B[k][j], wrapped to 32 bits
    function automatic logic [31:0] ref_c(int s, int i, int j);
        logic [31:0] acc;
        acc = '0;
        for (int k = 0; k < k_of[s]; k++) begin
            acc = acc + 32'(a_m[s][i][k] * b_m[s][k][j]);
        end
        return acc;
    endfunction

    task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            mism++;
            $display("mismatch at %0t: %s got %08h expected %08h", $time, name, got, exp);
        end
    endtask

    // 25% stall per channel when enabled
    always @(negedge clk) begin
        logic [31:0] r;
        if (stall_en) begin
            for (int c = 0; c < 4; c++) begin
                r = random_bits(2);
                stall[c] = &r[1:0];
            end
        end else begin
            stall = '0;
        end
    end

    // C is complete once done_o rises
    always @(posedge done) begin
        int s;
        int cb;
        if (pend.size() > 0) begin
            s = pend.pop_front();
            cb = ('h800 + (s % 4) * 'h40) / 4;
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    check_val($sformatf("C%0d[%0d][%0d]", s, i, j),
                              i_mem.mem[cb + i*4 + j], ref_c(s, i, j));
                end
            end
            checked++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic load_word(int idx, int val);
        @(negedge clk);
        ld_en = 1'b1;
        ld_addr = 10'(idx);
        ld_data = val;
    endtask

    task automatic load_set(int s);
        for (int k = 0; k < k_of[s]; k++) begin
            for (int i = 0; i < 4; i++) begin
                // A column-major, B row-major
                load_word(('h000 + (s % 2) * 'h100) / 4 + k*4 + i, a_m[s][i][k]);
                load_word(('h400 + (s % 2) * 'h100) / 4 + k*4 + i, b_m[s][k][i]);
            end
        end
        @(negedge clk);
        ld_en = 1'b0;
    endtask

    // called on a falling edge, start goes high right away
    task automatic start_run(int s);
        a_addr = 'h000 + (s % 2) * 'h100;
        b_addr = 'h400 + (s % 2) * 'h100;
        c_addr = 'h800 + (s % 4) * 'h40;
        mat_k = 5'(k_of[s]);
        start = 1'b1;
        pend.push_back(s);
        @(negedge clk);
        start = 1'b0;
        check_val("done_o after start", 32'(done), 32'd0);
    endtask

    task automatic wait_done();
        @(negedge clk);
        while (!done) begin
            @(negedge clk);
        end
    endtask

    initial begin
        logic [31:0] r;
        // small signed operands
        for (int s = 0; s < NRUN; s++) begin
            for (int i = 0; i < 4; i++) begin
                for (int k = 0; k < 16; k++) begin
                    r = random_bits(8);
                    a_m[s][i][k] = int'($signed(r[7:0]));
                    r = random_bits(8);
                    b_m[s][k][i] = int'($signed(r[7:0]));
                end
            end
        end
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_val("done_o after reset", 32'(done), 32'd1);
        load_set(0);
        start_run(0);
        wait_done();
        load_set(1);
        start_run(1);
        wait_done();
        stall_en = 1'b1;
        load_set(2);
        start_run(2);
        wait_done();
        stall_en = 1'b0;
        // second run starts the moment the first ends
        load_set(3);
        start_run(3);
        load_set(4);
        wait_done();
        start_run(4);
        wait_done();
        load_set(5);
        start_run(5);
        repeat (10) @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        wait_done();
        repeat (4) @(negedge clk);
        check_val("wr_bursts", 32'(wr_bursts), 32'(NRUN));
        check_val("runs_checked", 32'(checked), 32'(NRUN));
        other = addr_err;
        $display("errors: %0d mismatches, %0d other failures", mism, other);
        if (mism == 0 && other == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
